//--- verilog/cpuIoPkg.sv
// ====================
// CPU I/O register package
// Offsets of the $42xx page, data widths and math FSM states
// ====================
`default_nettype none

package cpuIoPkg;

    typedef logic [7:0]  regAddrT;  // Offset within $42xx
    typedef logic [7:0]  byteT;
    typedef logic [15:0] wordT;     // Math operand or result
    typedef logic [8:0]  lineCntT;  // Dot/line count and compare
    typedef logic [1:0]  irqModeT;  // 0 off, 1 H, 2 V, 3 HV

    typedef enum logic [1:0] {
        mathIdle,
        mathMul,
        mathDiv
    } mathStateT;

    // Write side
    localparam regAddrT A_NMITIMEN = 8'h00;
    localparam regAddrT A_WRMPYA   = 8'h02;
    localparam regAddrT A_WRMPYB   = 8'h03;
    localparam regAddrT A_WRDIVL   = 8'h04;
    localparam regAddrT A_WRDIVH   = 8'h05;
    localparam regAddrT A_WRDIVB   = 8'h06;
    localparam regAddrT A_HTIMEL   = 8'h07;
    localparam regAddrT A_HTIMEH   = 8'h08;
    localparam regAddrT A_VTIMEL   = 8'h09;
    localparam regAddrT A_VTIMEH   = 8'h0A;

    // Read side
    localparam regAddrT A_RDNMI    = 8'h10;
    localparam regAddrT A_TIMEUP   = 8'h11;
    localparam regAddrT A_HVBJOY   = 8'h12;
    localparam regAddrT A_RDDIVL   = 8'h14;
    localparam regAddrT A_RDDIVH   = 8'h15;
    localparam regAddrT A_RDMPYL   = 8'h16;
    localparam regAddrT A_RDMPYH   = 8'h17;

    localparam int MUL_STEPS   = 8;
    localparam int DIV_STEPS   = 16;
    localparam int CPU_VERSION = 2;  // Low nibble of RDNMI

endpackage

`default_nettype wire

//--- verilog/regWriteDecode.sv
// ====================
// Register write decoder
// Holds NMITIMEN, math operands and timer compares,
// fires math start and IRQ clear pulses
// ====================
`default_nettype none

module regWriteDecode import cpuIoPkg::*; (
    input  wire     WCLK,
    input  wire     RST_N,
    input  regAddrT regAddr,
    input  byteT    regWrData,
    input  wire     regWr,
    output logic    nmiEnable,
    output irqModeT irqMode,
    output lineCntT hTime,
    output lineCntT vTime,
    output logic    mulStart,
    output logic    divStart,
    output byteT    mulA,
    output byteT    mulB,
    output wordT    divA,
    output byteT    divB,
    output logic    irqWrClr
);

    byteT mulBReg;
    byteT divBReg;

    // Start pulses live in the write cycle itself
    assign mulStart = regWr && (regAddr == A_WRMPYB);
    assign divStart = regWr && (regAddr == A_WRDIVB);
    assign irqWrClr = regWr && (regAddr == A_NMITIMEN) && (regWrData[5:4] == 2'b00);

    // Fresh divisor/multiplier bypasses the register
    assign mulB = mulStart ? regWrData : mulBReg;
    assign divB = divStart ? regWrData : divBReg;

    always_ff @(posedge WCLK) begin
        if (!RST_N) begin
            nmiEnable <= 1'b0;
            irqMode   <= 2'b00;
            hTime     <= '1;
            vTime     <= '1;
        end else if (regWr) begin
            case (regAddr)
                A_NMITIMEN: begin
                    nmiEnable <= regWrData[7];
                    irqMode   <= regWrData[5:4];
                end
                A_HTIMEL: hTime[7:0] <= regWrData;
                A_HTIMEH: hTime[8]   <= regWrData[0];  // Only bit 0 is kept
                A_VTIMEL: vTime[7:0] <= regWrData;
                A_VTIMEH: vTime[8]   <= regWrData[0];
                default: ;
            endcase
        end
    end

    // Operand bytes
    always_ff @(posedge WCLK) begin
        if (regWr) begin
            case (regAddr)
                A_WRMPYA: mulA      <= regWrData;
                A_WRMPYB: mulBReg   <= regWrData;
                A_WRDIVL: divA[7:0] <= regWrData;
                A_WRDIVH: divA[15:8] <= regWrData;
                A_WRDIVB: divBReg   <= regWrData;
                default: ;
            endcase
        end
    end

    // A clearing NMITIMEN write also turns the timer mode off
    assert property (@(posedge WCLK) disable iff (!RST_N) irqWrClr |=> (irqMode == 2'b00));

endmodule

`default_nettype wire

//--- verilog/mathUnit.sv
// ====================
// Hardware multiply/divide
// 8x8 shift-add multiply and 16/8 restoring divide,
// one step per clock, shared result registers
// ====================
`default_nettype none

module mathUnit import cpuIoPkg::*; (
    input  wire  WCLK,
    input  wire  RST_N,
    input  wire  mulStart,
    input  wire  divStart,
    input  byteT mulA,
    input  byteT mulB,
    input  byteT divB,
    input  wordT divA,
    output wordT quotient,
    output wordT product
);

    mathStateT   mathState;
    logic [4:0]  stepCnt;
    logic [22:0] workShift;  // Shifted multiplicand or divisor
    logic        lastStep;
    logic        divFits;

    assign lastStep = ((mathState == mathMul) && (stepCnt == 5'(MUL_STEPS - 1))) ||
                      ((mathState == mathDiv) && (stepCnt == 5'(DIV_STEPS - 1)));
    assign divFits  = ({7'd0, product} >= workShift);

    always_ff @(posedge WCLK) begin
        if (!RST_N) begin
            mathState <= mathIdle;
            stepCnt   <= '0;
        end else if (mulStart) begin  // Restarts a busy unit too
            mathState <= mathMul;
            stepCnt   <= '0;
        end else if (divStart) begin
            mathState <= mathDiv;
            stepCnt   <= '0;
        end else if (mathState != mathIdle) begin
            stepCnt <= stepCnt + 5'd1;
            if (lastStep)
                mathState <= mathIdle;
        end
    end

    // Multiply: quotient holds {B, A} and drains A's bits from the bottom
    // Divide: product holds the running remainder
    always_ff @(posedge WCLK) begin
        if (mulStart) begin
            product   <= '0;
            quotient  <= {mulB, mulA};
            workShift <= {15'd0, mulB};
        end else if (divStart) begin
            product   <= divA;
            quotient  <= '0;
            workShift <= {divB, 15'd0};
        end else if (mathState == mathMul) begin
            if (quotient[0])
                product <= product + workShift[15:0];
            quotient  <= {1'b0, quotient[15:1]};
            workShift <= {workShift[21:0], 1'b0};
        end else if (mathState == mathDiv) begin
            if (divFits) begin
                product  <= product - workShift[15:0];
                quotient <= {quotient[14:0], 1'b1};
            end else begin
                quotient <= {quotient[14:0], 1'b0};
            end
            workShift <= {1'b0, workShift[22:1]};  // Zero divisor always fits
        end
    end

    assert property (@(posedge WCLK) disable iff (!RST_N) stepCnt <= 5'(DIV_STEPS));

endmodule

`default_nettype wire

//--- verilog/hvTimer.sv
// ====================
// H/V timer and NMI flag
// Dot/line counters, programmable H, V or HV IRQ,
// vertical blank NMI flag
// ====================
`default_nettype none

module hvTimer import cpuIoPkg::*; (
    input  wire     WCLK,
    input  wire     RST_N,
    input  wire     hBlank,
    input  wire     vBlank,
    input  irqModeT irqMode,
    input  lineCntT hTime,
    input  lineCntT vTime,
    input  wire     irqWrClr,
    input  wire     irqRdClr,
    input  wire     nmiRdClr,
    output logic    nmiFlag,
    output logic    irqFlag
);

    logic    dotEn;
    logic    hBlankR;
    logic    vBlankR;
    lineCntT hCnt;
    lineCntT vCnt;
    logic    hBlankFall;
    logic    vBlankFall;
    logic    vBlankRise;
    logic    hHit;
    logic    vHit;
    logic    match;
    logic    matchR;

    assign hBlankFall = hBlankR && !hBlank;
    assign vBlankFall = vBlankR && !vBlank;
    assign vBlankRise = !vBlankR && vBlank;

    always_ff @(posedge WCLK) begin
        if (!RST_N) begin
            dotEn   <= 1'b0;
            hBlankR <= 1'b0;
            vBlankR <= 1'b0;
            hCnt    <= '0;
            vCnt    <= '0;
        end else begin
            dotEn   <= !dotEn;  // One dot every two clocks
            hBlankR <= hBlank;
            vBlankR <= vBlank;
            if (vBlankFall) begin  // New frame
                hCnt <= '0;
                vCnt <= '0;
            end else if (hBlankFall) begin
                hCnt <= '0;
                vCnt <= vCnt + 9'd1;
            end else if (dotEn) begin
                hCnt <= hCnt + 9'd1;
            end
        end
    end

    assign hHit = (hCnt == hTime);
    assign vHit = (vCnt == vTime);

    always_comb begin
        case (irqMode)
            2'd1:    match = hHit;
            2'd2:    match = vHit;
            2'd3:    match = hHit && vHit;
            default: match = 1'b0;
        endcase
    end

    always_ff @(posedge WCLK) begin
        if (!RST_N) begin
            matchR  <= 1'b0;
            irqFlag <= 1'b0;
            nmiFlag <= 1'b0;
        end else begin
            if (dotEn)
                matchR <= match;
            if (irqWrClr || irqRdClr)
                irqFlag <= 1'b0;
            else if (dotEn && match && !matchR)  // Rising edge of match only
                irqFlag <= 1'b1;

            if (vBlankRise)
                nmiFlag <= 1'b1;
            else if (vBlankFall || nmiRdClr)
                nmiFlag <= 1'b0;
        end
    end

    assert property (@(posedge WCLK) disable iff (!RST_N)
        $rose(irqFlag) |-> ($past(irqMode) != 2'd0));

endmodule

`default_nettype wire

//--- verilog/regReadMux.sv
// ====================
// Register read mux
// Returns read data for the $42xx page and
// flags the clear-on-read accesses
// ====================
`default_nettype none

module regReadMux import cpuIoPkg::*; (
    input  regAddrT regAddr,
    input  wire     regRd,
    input  wire     hBlank,
    input  wire     vBlank,
    input  wire     nmiFlag,
    input  wire     irqFlag,
    input  wordT    quotient,
    input  wordT    product,
    output byteT    regRdData,
    output logic    nmiRdClr,
    output logic    irqRdClr
);

    assign nmiRdClr = regRd && (regAddr == A_RDNMI);
    assign irqRdClr = regRd && (regAddr == A_TIMEUP);

    always_comb begin
        case (regAddr)
            A_RDNMI:  regRdData = {nmiFlag, 3'b000, 4'(CPU_VERSION)};
            A_TIMEUP: regRdData = {irqFlag, 7'd0};
            A_HVBJOY: regRdData = {vBlank, hBlank, 6'd0};  // No joypad busy bit
            A_RDDIVL: regRdData = quotient[7:0];
            A_RDDIVH: regRdData = quotient[15:8];
            A_RDMPYL: regRdData = product[7:0];
            A_RDMPYH: regRdData = product[15:8];
            default:  regRdData = 8'h00;  // Unmapped
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/cpuIoTop.sv
// ====================
// CPU I/O block top
// Multiplier, divider, H/V timer and NMI on a plain register bus
// ====================
`default_nettype none

module cpuIoTop import cpuIoPkg::*; (
    input  wire     WCLK,
    input  wire     RST_N,
    input  regAddrT regAddr,
    input  byteT    regWrData,
    input  wire     regWr,
    input  wire     regRd,
    output byteT    regRdData,
    input  wire     hBlank,
    input  wire     vBlank,
    output logic    nmiN,
    output logic    irqN
);

    logic    nmiEnable;
    irqModeT irqMode;
    lineCntT hTime;
    lineCntT vTime;
    logic    mulStart;
    logic    divStart;
    byteT    mulA;
    byteT    mulB;
    wordT    divA;
    byteT    divB;
    logic    irqWrClr;
    logic    irqRdClr;
    logic    nmiRdClr;
    wordT    quotient;
    wordT    product;
    logic    nmiFlag;
    logic    irqFlag;

    regWriteDecode u_regWriteDecode (
        .WCLK      (WCLK),
        .RST_N     (RST_N),
        .regAddr   (regAddr),
        .regWrData (regWrData),
        .regWr     (regWr),
        .nmiEnable (nmiEnable),
        .irqMode   (irqMode),
        .hTime     (hTime),
        .vTime     (vTime),
        .mulStart  (mulStart),
        .divStart  (divStart),
        .mulA      (mulA),
        .mulB      (mulB),
        .divA      (divA),
        .divB      (divB),
        .irqWrClr  (irqWrClr)
    );

    mathUnit u_mathUnit (
        .WCLK     (WCLK),
        .RST_N    (RST_N),
        .mulStart (mulStart),
        .divStart (divStart),
        .mulA     (mulA),
        .mulB     (mulB),
        .divB     (divB),
        .divA     (divA),
        .quotient (quotient),
        .product  (product)
    );

    hvTimer u_hvTimer (
        .WCLK     (WCLK),
        .RST_N    (RST_N),
        .hBlank   (hBlank),
        .vBlank   (vBlank),
        .irqMode  (irqMode),
        .hTime    (hTime),
        .vTime    (vTime),
        .irqWrClr (irqWrClr),
        .irqRdClr (irqRdClr),
        .nmiRdClr (nmiRdClr),
        .nmiFlag  (nmiFlag),
        .irqFlag  (irqFlag)
    );

    regReadMux u_regReadMux (
        .regAddr   (regAddr),
        .regRd     (regRd),
        .hBlank    (hBlank),
        .vBlank    (vBlank),
        .nmiFlag   (nmiFlag),
        .irqFlag   (irqFlag),
        .quotient  (quotient),
        .product   (product),
        .regRdData (regRdData),
        .nmiRdClr  (nmiRdClr),
        .irqRdClr  (irqRdClr)
    );

    // Active-low interrupt lines to the CPU
    assign nmiN = !(nmiEnable && nmiFlag);
    assign irqN = !irqFlag;

endmodule

`default_nettype wire

//--- verif/cpuIoTb.sv
// ====================
// CPU I/O block testbench
// Random multiply/divide against a model, NMI, H-IRQ and HVBJOY
// ====================
`default_nettype none

module cpuIoTb import cpuIoPkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int MUL_TRIALS  = 200;
    localparam int DIV_TRIALS  = 200;
    localparam int HV_TRIALS   = 40;
    // Reset, multiply, divide, NMI, H-IRQ, HVBJOY
    localparam int TEST_CYCLES = 8 + MUL_TRIALS * 15 + DIV_TRIALS * 24 + 16 + 440
                                 + HV_TRIALS * 2;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic    WCLK = 1'b0;
    logic    RST_N;
    regAddrT regAddr;
    byteT    regWrData;
    logic    regWr;
    logic    regRd;
    byteT    regRdData;
    logic    hBlank;
    logic    vBlank;
    logic    nmiN;
    logic    irqN;
    int      cycleCnt = 0;

    cpuIoTop u_dut (
        .WCLK      (WCLK),
        .RST_N     (RST_N),
        .regAddr   (regAddr),
        .regWrData (regWrData),
        .regWr     (regWr),
        .regRd     (regRd),
        .regRdData (regRdData),
        .hBlank    (hBlank),
        .vBlank    (vBlank),
        .nmiN      (nmiN),
        .irqN      (irqN)
    );

    always #10 WCLK = !WCLK;  // 20 ns period

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    always @(posedge WCLK) begin
        cycleCnt = cycleCnt + 1;
        if (cycleCnt > MAX_CYCLES)
            abortRun($sformatf("Timeout after %0d cycles, the run never finished", MAX_CYCLES));
    end

    task automatic checkValue(input string name, input byteT actual, input byteT expected);
        if (actual !== expected)
            abortRun($sformatf("CHECK FAILED at %0t ns: %s = 0x%02h, expected 0x%02h",
                               $time, name, actual, expected));
    endtask

    // Bus tasks start and end on a falling edge
    task automatic busWrite(input regAddrT addr, input byteT data);
        regAddr   = addr;
        regWrData = data;
        regWr     = 1'b1;
        @(negedge WCLK);
        regWr = 1'b0;
    endtask

    task automatic readReg(input regAddrT addr, output byteT data);
        regAddr = addr;
        regRd   = 1'b1;
        #1 data = regRdData;  // Read data is combinational
        @(negedge WCLK);
        regRd = 1'b0;
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(negedge WCLK);
    endtask

    function automatic wordT mulModel(input byteT a, input byteT b);
        return wordT'(a) * wordT'(b);
    endfunction

    // Division by zero gives all ones and leaves the dividend as remainder
    function automatic void divModel(input wordT a, input byteT b, output wordT q,
                                     output wordT r);
        if (b == 8'h00) begin
            q = 16'hFFFF;
            r = a;
        end else begin
            q = a / wordT'(b);
            r = a % wordT'(b);
        end
    endfunction

    task automatic testReset();
        byteT rd;
        readReg(A_RDNMI, rd);
        checkValue("RDNMI", rd, 8'h02);
        readReg(A_TIMEUP, rd);
        checkValue("TIMEUP", rd, 8'h00);
        checkValue("nmiN", byteT'(nmiN), 8'h01);
        checkValue("irqN", byteT'(irqN), 8'h01);
    endtask

    task automatic testMultiply();
        byteT a;
        byteT b;
        byteT rd;
        wordT expProd;
        int   i;
        for (i = 0; i < MUL_TRIALS; i++) begin
            a       = byteT'($urandom);
            b       = byteT'($urandom);
            expProd = mulModel(a, b);
            busWrite(A_WRMPYA, a);
            busWrite(A_WRMPYB, b);
            waitCycles(9);
            readReg(A_RDMPYL, rd);
            checkValue("RDMPYL", rd, expProd[7:0]);
            readReg(A_RDMPYH, rd);
            checkValue("RDMPYH", rd, expProd[15:8]);
            readReg(A_RDDIVL, rd);
            checkValue("RDDIVL", rd, b);  // Quotient ends up holding B
            readReg(A_RDDIVH, rd);
            checkValue("RDDIVH", rd, 8'h00);
        end
    endtask

    task automatic testDivide();
        wordT a;
        byteT b;
        byteT rd;
        wordT expQuot;
        wordT expRem;
        int   i;
        for (i = 0; i < DIV_TRIALS; i++) begin
            a = wordT'($urandom);
            b = (i % 8 == 0) ? 8'h00 : byteT'($urandom);  // Every 8th divisor is zero
            divModel(a, b, expQuot, expRem);
            busWrite(A_WRDIVL, a[7:0]);
            busWrite(A_WRDIVH, a[15:8]);
            busWrite(A_WRDIVB, b);
            waitCycles(17);
            readReg(A_RDDIVL, rd);
            checkValue("RDDIVL", rd, expQuot[7:0]);
            readReg(A_RDDIVH, rd);
            checkValue("RDDIVH", rd, expQuot[15:8]);
            readReg(A_RDMPYL, rd);
            checkValue("RDMPYL", rd, expRem[7:0]);
            readReg(A_RDMPYH, rd);
            checkValue("RDMPYH", rd, expRem[15:8]);
        end
    endtask

    task automatic testNmi();
        byteT rd;
        busWrite(A_NMITIMEN, 8'h80);
        vBlank = 1'b1;
        waitCycles(2);
        checkValue("nmiN", byteT'(nmiN), 8'h00);
        readReg(A_RDNMI, rd);
        checkValue("RDNMI", rd, 8'h82);
        checkValue("nmiN", byteT'(nmiN), 8'h01);  // Cleared by the read
        readReg(A_RDNMI, rd);
        checkValue("RDNMI", rd, 8'h02);
        vBlank = 1'b0;
        waitCycles(2);
    endtask

    // Restart the H count with an hBlank pulse and wait for the H-IRQ
    task automatic waitHIrq(input int hTimeVal);
        int waited;
        hBlank = 1'b1;
        waitCycles(2);
        hBlank = 1'b0;  // Falling edge restarts the H count
        busWrite(A_NMITIMEN, 8'h10);
        waited = 1;
        while (irqN && waited < 2 * hTimeVal + 6) begin
            @(negedge WCLK);
            waited++;
        end
        if (irqN)
            abortRun($sformatf("irqN did not go low within %0d cycles for hTime %0d",
                               2 * hTimeVal + 6, hTimeVal));
        else if (waited < 2 * hTimeVal - 2)
            abortRun($sformatf("irqN went low too early, after %0d cycles for hTime %0d",
                               waited, hTimeVal));
    endtask

    task automatic testHIrq();
        byteT rd;
        int   hTimeVal;
        hTimeVal = 4 + int'($urandom % 97);
        busWrite(A_HTIMEL, byteT'(hTimeVal));
        busWrite(A_HTIMEH, 8'h00);
        waitHIrq(hTimeVal);
        readReg(A_TIMEUP, rd);
        checkValue("TIMEUP", rd, 8'h80);
        checkValue("irqN", byteT'(irqN), 8'h01);
        waitHIrq(hTimeVal);
        busWrite(A_NMITIMEN, 8'h00);  // Mode 0 drops the pending IRQ
        checkValue("irqN", byteT'(irqN), 8'h01);
    endtask

    task automatic testHvbjoy();
        byteT rd;
        int   i;
        for (i = 0; i < HV_TRIALS; i++) begin
            hBlank = 1'($urandom);
            vBlank = 1'($urandom);
            readReg(A_HVBJOY, rd);
            checkValue("HVBJOY", rd, {vBlank, hBlank, 6'd0});
        end
    endtask

    initial begin
        void'($urandom(12));
        RST_N     = 1'b0;
        regAddr   = '0;
        regWrData = '0;
        regWr     = 1'b0;
        regRd     = 1'b0;
        hBlank    = 1'b0;
        vBlank    = 1'b0;
        waitCycles(4);
        RST_N = 1'b1;

        testReset();
        testMultiply();
        testDivide();
        testNmi();
        testHIrq();
        testHvbjoy();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpuIoTop.f
verilog/cpuIoPkg.sv
verilog/regWriteDecode.sv
verilog/mathUnit.sv
verilog/hvTimer.sv
verilog/regReadMux.sv
verilog/cpuIoTop.sv
verif/cpuIoTb.sv

//--- run.sh
#!/bin/sh
# Build the cpuIoTop testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns --top-module cpuIoTb \
    -f cpuIoTop.f -o cpuIoSim \
    && ./obj_dir/cpuIoSim | tee /dev/stderr | grep -qx "test passed" \
    && echo "simulation OK" \
    || { echo "simulation FAILED"; exit 1; }
